// ==== cpu16.f ====
src/cpu16_pkg.sv
src/apb_if.sv
src/alu.sv
src/ex_unit.sv
src/cpu_ctrl.sv
src/apb_arbiter.sv
src/apb_sram.sv
src/cpu16_top.sv
dv/cpu16_tb.sv

// ==== dv/cpu16_tb.sv ====
// Trace-driven testbench that loads, runs and checks cpu16 programs through the host APB port
`timescale 1ns/1ns
`default_nettype none

module cpu16_tb import cpu16_pkg::*; ();

    localparam int apb_timeout  = 200;             // Cycles per host transfer
    localparam int halt_timeout = 4000;            // Cycles per program run

    logic  clk, arst_n, start;
    logic  halted, busy;
    logic  host_psel, host_penable, host_pwrite;
    word_t host_paddr, host_pwdata, host_prdata;
    logic  host_pready;

    integer           fd, code, seed;
    integer           errors, test_errors, pass_cnt, fail_cnt;
    logic             in_test;
    logic [8*16-1:0]  cmd;                         // Trace command word
    logic [8*32-1:0]  test_name;
    logic [8*128-1:0] rest_of_line;
    word_t            addr, data, count, k, dummy;

    cpu16_top #(
        .depth       (1024),
        .wait_states (1),
        .stack_top   (16'h0400)
    ) dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .halted       (halted),
        .busy         (busy),
        .host_psel    (host_psel),
        .host_penable (host_penable),
        .host_pwrite  (host_pwrite),
        .host_paddr   (host_paddr),
        .host_pwdata  (host_pwdata),
        .host_prdata  (host_prdata),
        .host_pready  (host_pready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                          // 10 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Host APB master and core control
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_xfer(input logic write, input word_t a, input word_t wd,
                            output word_t rd);
        int n;
        @(posedge clk);
        #1;
        host_psel    = 1'b1;                       // Setup phase
        host_penable = 1'b0;
        host_pwrite  = write;
        host_paddr   = a;
        host_pwdata  = wd;
        @(posedge clk);
        #1;
        host_penable = 1'b1;                       // Access phase until pready
        for (n = 0; n < apb_timeout; n++) begin
            @(negedge clk);
            if (host_pready) break;
        end
        rd = host_prdata;
        if (n == apb_timeout) begin
            $display("Host APB transfer to address %h never got pready", a);
            test_errors++;
        end
        @(posedge clk);
        #1;
        host_psel    = 1'b0;
        host_penable = 1'b0;
    endtask

    task automatic check_word(input word_t a, input word_t exp);
        word_t got;
        apb_xfer(1'b0, a, 16'h0000, got);
        assert (got === exp) else begin
            $display("ERROR %0t: address %h expected %h got %h", $time, a, exp, got);
            test_errors++;
        end
    endtask

    task automatic start_core();
        @(posedge clk);
        #1;
        start = 1'b1;                              // One-cycle pulse
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy === 1'b1 && halted === 1'b0) else begin
            $display("ERROR %0t: after start expected busy 1 halted 0 got busy %b halted %b",
                     $time, busy, halted);
            test_errors++;
        end
    endtask

    task automatic wait_halted();
        int n;
        for (n = 0; n < halt_timeout; n++) begin
            @(negedge clk);
            if (halted) break;
        end
        if (n == halt_timeout) begin
            $display("Core did not reach halted within %0d cycles", halt_timeout);
            test_errors++;
        end else begin
            assert (busy == 1'b0) else begin
                $display("ERROR %0t: busy still high after halted", $time);
                test_errors++;
            end
        end
    endtask

    // Host reads of a fixed word while the core competes for the SRAM
    task automatic contend_reads(input word_t reads, input word_t exp);
        word_t i;
        int    gap;
        start_core();
        for (i = 0; i < reads; i++) begin
            gap = $unsigned($random(seed)) % 8;
            repeat (gap) @(posedge clk);
            check_word(16'h03F0, exp);
        end
        wait_halted();
    endtask

    task automatic close_test();
        if (in_test) begin
            if (test_errors == 0) begin
                $display("test %0s: passed", test_name);
                pass_cnt++;
            end else begin
                $display("test %0s: failed with %0d errors", test_name, test_errors);
                fail_cnt++;
            end
        end
        errors      += test_errors;
        test_errors  = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace interpreter
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed         = 32'h0baf5d4d;
        errors       = 0;
        test_errors  = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        in_test      = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        host_psel    = 1'b0;
        host_penable = 1'b0;
        host_pwrite  = 1'b0;
        host_paddr   = '0;
        host_pwdata  = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        fd = $fopen("dv/cpu16_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file dv/cpu16_trace.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    code = $fgets(rest_of_line, fd);   // Comment line
                end else if (cmd == "test") begin
                    close_test();
                    code    = $fscanf(fd, "%s", test_name);
                    in_test = 1'b1;
                end else if (cmd == "write") begin
                    code = $fscanf(fd, "%h %h", addr, count);
                    for (k = 0; k < count; k++) begin
                        code = $fscanf(fd, "%h", data);
                        apb_xfer(1'b1, addr + k, data, dummy);
                    end
                end else if (cmd == "expect") begin
                    code = $fscanf(fd, "%h %h", addr, count);
                    for (k = 0; k < count; k++) begin
                        code = $fscanf(fd, "%h", data);
                        check_word(addr + k, data);
                    end
                end else if (cmd == "run") begin
                    start_core();
                    wait_halted();
                end else if (cmd == "contend") begin
                    code = $fscanf(fd, "%h %h", count, data);
                    contend_reads(count, data);
                end else begin
                    $display("Unknown trace command %0s", cmd);
                    errors++;
                end
            end
            close_test();
            $fclose(fd);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (errors == 0 && pass_cnt > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpu16_trace.txt ====
# Commands: test <name> | write <addr> <n> <n words> | expect <addr> <n> <n words>
# run | contend <reads> <word at 03f0>; every number is hex, counts too
test alu_imm
write 03f0 1 c0de
write 0100 2 1234 0f0f
write 0000 8 8101 8e02 9210 9311 0423 1523 2623 3723
write 0008 8 4823 5924 6a23 7b2d 83ab a4e0 a5e1 a6e2
write 0010 7 a7e3 a8e4 a9e5 aae6 abe7 a3e8 e000
run
expect 0200 8 2143 0325 0204 1f3f 1d3b 2340 0246 1231
expect 01f8 1 ab0f
# Markers at 02f8..02fc and 0300..0307, the rest stays zero
test flags_branch
write 0104 4 0001 0002 8000 5a5a
write 02f8 10 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
write 0000 8 8101 8d03 9214 9315 9416 9717 b001 e000
write 0008 8 a7d0 1522 b201 e000 a7d1 b401 b001 e000
write 0010 8 a7d2 0523 b201 b001 e000 a7d3 b401 e000
write 0018 8 a7d4 b801 e000 a7d5 b601 b001 e000 a7d6
write 0020 8 ba01 b001 e000 a7d7 1523 b601 e000 a7d8
write 0028 8 b801 b001 e000 a7d9 ba01 e000 a7da 0544
write 0030 8 ba01 e000 a7db b002 a7dc e000 b1fd e000
run
expect 02f8 10 5a5a 5a5a 5a5a 5a5a 5a5a 0000 0000 0000 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a
test call_ret
write 00f8 5 0000 0000 0000 0000 0000
write 03fe 2 0000 0000
write 0000 6 8c01 c010 afc8 a2c9 a3ca e000
write 0010 5 7205 afcb c020 7331 d000
write 0020 3 7306 afcc d000
run
expect 00f8 5 0400 0005 0007 03ff 03fe
expect 03fe 2 0013 0002
test load_store
write 0102 2 1111 00f0
write 01f9 3 0000 0000 0000
write 0000 8 8101 8e02 9212 9313 0423 4542 a4e9 a5ea
write 0008 4 96e9 7667 a6eb e000
run
expect 01f9 3 1201 0310 1208
test contend_alu
write 0000 8 8101 8e02 9210 9311 0423 1523 2623 3723
write 0008 8 4823 5924 6a23 7b2d 83ab a4e0 a5e1 a6e2
write 0010 7 a7e3 a8e4 a9e5 aae6 abe7 a3e8 e000
write 0200 8 0000 0000 0000 0000 0000 0000 0000 0000
write 01f8 1 0000
contend 10 c0de
expect 0200 8 2143 0325 0204 1f3f 1d3b 2340 0246 1231
expect 01f8 1 ab0f
test contend_ldst
write 0000 8 8101 8e02 9212 9313 0423 4542 a4e9 a5ea
write 0008 4 96e9 7667 a6eb e000
write 01f9 3 0000 0000 0000
contend 10 c0de
expect 01f9 3 1201 0310 1208
test restart
write 00ff 1 0000
write 0000 4 8101 780f a81f e000
run
expect 00ff 1 ffff

// ==== run.sh ====
#!/bin/sh
# Build the cpu16 testbench with Verilator, run it from the project root and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu16_tb -f cpu16.f \
    -o cpu16_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/cpu16_sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation gave no result, see sim.log"; exit 1; }
echo "Simulation passed"

// ==== src/alu.sv ====
// Combinational 16-bit ALU of the execute stage, giving a result and its z/n/c flags
`timescale 1ns/1ns
`default_nettype none

module alu import cpu16_pkg::*; (
    input  word_t      a,                        // Operand 1, rs1
    input  word_t      b,                        // Operand 2, rs2 or immediate
    input  logic [3:0] shamt,                    // Shift amount
    input  logic [7:0] imm8,                     // High byte for lhi
    input  alu_op_e    op,
    output word_t      result,
    output flags_t     flags
);

    logic [16:0] wide;                           // Result plus carry-out bit
    logic        carry;

    always_comb begin
        wide   = '0;
        result = '0;
        carry  = 1'b0;
        case (op)
            alu_add: begin
                wide   = {1'b0, a} + {1'b0, b};
                result = wide[15:0];
                carry  = wide[16];
            end
            alu_sub: begin
                wide   = {1'b0, a} - {1'b0, b};  // Bit 16 set on borrow
                result = wide[15:0];
                carry  = wide[16];
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_shl: begin
                wide   = {1'b0, a} << shamt;     // Last bit out lands in bit 16
                result = wide[15:0];
                carry  = wide[16];
            end
            alu_shr: begin
                wide   = {a, 1'b0} >> shamt;     // Last bit out lands in bit 0
                result = wide[16:1];
                carry  = wide[0];
            end
            alu_lhi: result = {imm8, a[7:0]};    // Keep low byte of rd
            default: result = '0;
        endcase
    end

    assign flags.z = (result == '0);
    assign flags.n = result[15];
    assign flags.c = carry;                      // Zero for logic ops and lhi

endmodule

`default_nettype wire

// ==== src/apb_arbiter.sv ====
// Round-robin arbiter sharing one APB slave between the host port and the core
`timescale 1ns/1ns
`default_nettype none

module apb_arbiter (
    input  logic  clk,
    input  logic  arst_n,
    apb_if.slave  host,
    apb_if.slave  core,
    apb_if.master mem
);

    logic active;                                // Transfer in flight on mem
    logic owner;                                 // Granted master, 1 = core
    logic last;                                  // Master granted last
    logic pick;                                  // Idle-state choice
    logic sel;

    // Tie goes to the master not granted last
    always_comb begin
        if (host.psel && core.psel) pick = ~last;
        else                        pick = core.psel;
    end

    assign sel = active ? owner : pick;          // No added cycle on grant

    assign mem.psel    = sel ? core.psel : host.psel;
    assign mem.penable = active && (sel ? core.penable : host.penable);  // Forces setup
    assign mem.pwrite  = sel ? core.pwrite : host.pwrite;
    assign mem.paddr   = sel ? core.paddr  : host.paddr;
    assign mem.pwdata  = sel ? core.pwdata : host.pwdata;

    assign host.prdata = mem.prdata;
    assign core.prdata = mem.prdata;
    assign host.pready = active && !owner && mem.pready;  // Loser sees pready low
    assign core.pready = active && owner && mem.pready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            owner  <= 1'b0;
            last   <= 1'b1;                      // Host wins the first tie
        end else if (!active) begin
            if (mem.psel) begin
                active <= 1'b1;
                owner  <= pick;
            end
        end else if (mem.penable && mem.pready) begin
            active <= 1'b0;                      // Re-arbitrate next cycle
            last   <= owner;
        end
    end

endmodule

`default_nettype wire

// ==== src/apb_if.sv ====
// APB bundle joining a master to a slave, with a monitor view for the testbench
`timescale 1ns/1ns
`default_nettype none

interface apb_if import cpu16_pkg::*; ();

    logic  psel;
    logic  penable;
    logic  pwrite;                               // 1 = write
    word_t paddr;                                // Word address
    word_t pwdata;
    word_t prdata;
    logic  pready;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

    modport monitor (
        input psel, penable, pwrite, paddr, pwdata, prdata, pready
    );

endinterface

`default_nettype wire

// ==== src/apb_sram.sv ====
// Word-addressed APB slave SRAM holding program and data, with optional wait states
`timescale 1ns/1ns
`default_nettype none

module apb_sram import cpu16_pkg::*; #(
    parameter int depth       = 1024,            // Words, power of two
    parameter int wait_states = 0
) (
    input  logic clk,
    input  logic arst_n,
    apb_if.slave bus
);

    localparam int aw = $clog2(depth);
    localparam int cw = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    word_t           mem [depth];
    logic [aw-1:0]   idx;                        // Address modulo depth
    logic [cw-1:0]   wait_cnt;
    logic            access;

    assign idx        = bus.paddr[aw-1:0];
    assign access     = bus.psel && bus.penable;
    assign bus.pready = access && (wait_cnt == cw'(wait_states));
    assign bus.prdata = mem[idx];                // Combinational read

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)                    wait_cnt <= '0;
        else if (access && !bus.pready) wait_cnt <= wait_cnt + 1'b1;
        else                            wait_cnt <= '0;
    end

    always_ff @(posedge clk) begin
        if (bus.pready && bus.pwrite) mem[idx] <= bus.pwdata;  // Write on last access cycle
    end

endmodule

`default_nettype wire

// ==== src/cpu16_pkg.sv ====
// Word, opcode, ALU, branch and FSM types shared by every cpu16 block via wildcard import
`default_nettype none

package cpu16_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes and fixed registers
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [15:0] word_t;                 // Data word, also the word address

    localparam logic [3:0] sp_reg = 4'd15;       // Stack pointer register index

    ////////////////////////////////////////////////////////////////////////////
    // Instruction set
    ////////////////////////////////////////////////////////////////////////////

    // Opcode lives in instr[15:12]; rd 11:8, rs1 7:4, rs2 or imm4 3:0
    typedef enum logic [3:0] {
        op_add  = 4'h0,                          // rd = rs1 + rs2
        op_sub  = 4'h1,                          // rd = rs1 - rs2
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_shl  = 4'h5,                          // rd = rs1 << imm4
        op_shr  = 4'h6,                          // rd = rs1 >> imm4
        op_addi = 4'h7,                          // rd = rs1 + sext(imm4)
        op_lhi  = 4'h8,                          // rd = {imm8, rd[7:0]}
        op_ld   = 4'h9,                          // rd = mem[rs1 + sext(imm4)]
        op_st   = 4'hA,                          // mem[rs1 + sext(imm4)] = rd
        op_br   = 4'hB,                          // Cond in 11:9, offset in 8:0
        op_call = 4'hC,                          // Push pc + 1, jump to 11:0
        op_ret  = 4'hD,                          // Pop pc
        op_halt = 4'hE
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_shl, alu_shr, alu_lhi
    } alu_op_e;

    typedef enum logic [2:0] {
        br_always = 3'd0,
        br_eq     = 3'd1,                        // z set
        br_ne     = 3'd2,
        br_lt     = 3'd3,                        // n set
        br_ge     = 3'd4,
        br_cs     = 3'd5                         // Carry or borrow set
    } br_cond_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

    typedef enum logic [2:0] {
        st_idle, st_fetch, st_exec, st_mem, st_wb, st_halt
    } core_state_e;

endpackage

`default_nettype wire

// ==== src/cpu16_top.sv ====
// Top of the cpu16 subsystem: core, APB arbiter and SRAM, host APB port as plain pins
`timescale 1ns/1ns
`default_nettype none

module cpu16_top import cpu16_pkg::*; #(
    parameter int    depth       = 1024,
    parameter int    wait_states = 0,
    parameter word_t stack_top   = 16'h0400
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    output logic  halted,
    output logic  busy,
    input  logic  host_psel,
    input  logic  host_penable,
    input  logic  host_pwrite,
    input  word_t host_paddr,
    input  word_t host_pwdata,
    output word_t host_prdata,
    output logic  host_pready
);

    apb_if host_bus ();
    apb_if core_bus ();
    apb_if mem_bus ();

    // Host pins onto the arbiter's host side
    assign host_bus.psel    = host_psel;
    assign host_bus.penable = host_penable;
    assign host_bus.pwrite  = host_pwrite;
    assign host_bus.paddr   = host_paddr;
    assign host_bus.pwdata  = host_pwdata;
    assign host_prdata      = host_bus.prdata;
    assign host_pready      = host_bus.pready;

    cpu_ctrl #(.stack_top(stack_top)) core_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .halted (halted),
        .busy   (busy),
        .bus    (core_bus)
    );

    apb_arbiter arb_i (
        .clk    (clk),
        .arst_n (arst_n),
        .host   (host_bus),
        .core   (core_bus),
        .mem    (mem_bus)
    );

    apb_sram #(.depth(depth), .wait_states(wait_states)) sram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (mem_bus)
    );

endmodule

`default_nettype wire

// ==== src/cpu_ctrl.sv ====
// Multicycle core controller: FSM, PC, register file, decode and APB master port
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl import cpu16_pkg::*; #(
    parameter word_t stack_top = 16'h0400        // Reset value of r15
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,                         // Run from address 0
    output logic  halted,
    output logic  busy,
    apb_if.master bus
);

    core_state_e state;
    word_t       pc, ir, rdata_q;                // rdata_q holds load data or popped PC
    word_t       regs [16];
    opcode_e     op;
    logic [3:0]  rs1_idx, rs2_idx, rd_idx, rd_wb;
    word_t       sign_ext, alu_result, store_data, pc_next;
    alu_op_e     alu_op;
    logic        alu_src, alu_class, reg_we, xfer_done;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign op        = opcode_e'(ir[15:12]);
    assign alu_class = (ir[15:12] <= op_lhi);    // add through lhi set flags
    assign reg_we    = alu_class || op inside {op_ld, op_call, op_ret};
    assign xfer_done = bus.psel && bus.penable && bus.pready;

    always_comb begin
        rs1_idx  = ir[7:4];
        rs2_idx  = ir[3:0];
        rd_idx   = ir[11:8];
        sign_ext = {{12{ir[3]}}, ir[3:0]};       // imm4 by default
        alu_src  = 1'b0;
        alu_op   = alu_add;
        case (op)
            op_sub: alu_op = alu_sub;
            op_and: alu_op = alu_and;
            op_or:  alu_op = alu_or;
            op_xor: alu_op = alu_xor;
            op_shl: alu_op = alu_shl;
            op_shr: alu_op = alu_shr;
            op_addi, op_ld: alu_src = 1'b1;
            op_lhi: begin
                alu_op  = alu_lhi;
                rs1_idx = ir[11:8];              // Low byte comes from rd
            end
            op_st: begin
                alu_src = 1'b1;
                rs2_idx = ir[11:8];              // Store data from rd
            end
            op_br: sign_ext = {{7{ir[8]}}, ir[8:0]};
            op_call: begin
                alu_src  = 1'b1;
                rs1_idx  = sp_reg;
                sign_ext = 16'hFFFF;             // SP - 1, push address and new SP
            end
            op_ret: begin
                alu_src  = 1'b1;
                rs1_idx  = sp_reg;
                rd_idx   = sp_reg;
                sign_ext = 16'h0001;             // SP + 1 written back
            end
            default: ;
        endcase
    end

    ex_unit ex_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs1_data    (regs[rs1_idx]),
        .rs2_data    (regs[rs2_idx]),
        .sign_ext    (sign_ext),
        .alu_src     (alu_src),
        .alu_op      (alu_op),
        .shamt       (ir[3:0]),
        .imm8        (ir[7:0]),
        .alu_done    (state == st_exec && alu_class),
        .branch      (op == op_br),
        .call        (op == op_call),
        .ret         (op == op_ret),
        .br_cond     (br_cond_e'(ir[11:9])),
        .call_target (ir[11:0]),
        .pc          (pc),
        .ret_addr    (rdata_q),
        .rd_in       (rd_idx),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .pc_next     (pc_next),
        .rd_out      (rd_wb),
        .flags       ()
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= (i == sp_reg) ? stack_top : '0;
            end
        end else if (state == st_wb && reg_we) begin
            regs[rd_wb] <= (op == op_ld) ? rdata_q : alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done && state == st_fetch) ir <= bus.prdata;
        if (xfer_done && state == st_mem)   rdata_q <= bus.prdata;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction FSM and APB master
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            pc          <= '0;
            halted      <= 1'b0;
            busy        <= 1'b0;
            bus.psel    <= 1'b0;
            bus.penable <= 1'b0;
            bus.pwrite  <= 1'b0;
            bus.paddr   <= '0;
            bus.pwdata  <= '0;
        end else begin
            case (state)
                st_idle, st_halt: if (start) begin
                    pc         <= '0;
                    halted     <= 1'b0;
                    busy       <= 1'b1;
                    bus.psel   <= 1'b1;          // Setup for fetch at 0
                    bus.pwrite <= 1'b0;
                    bus.paddr  <= '0;
                    state      <= st_fetch;
                end
                st_fetch, st_mem: begin
                    if (!bus.penable) begin
                        bus.penable <= 1'b1;     // Access phase
                    end else if (bus.pready) begin
                        bus.psel    <= 1'b0;
                        bus.penable <= 1'b0;
                        state       <= (state == st_fetch) ? st_exec : st_wb;
                    end
                end
                st_exec: begin
                    if (op == op_halt) begin
                        halted <= 1'b1;
                        busy   <= 1'b0;
                        state  <= st_halt;
                    end else if (op inside {op_ld, op_st, op_call, op_ret}) begin
                        bus.psel   <= 1'b1;
                        bus.pwrite <= (op == op_st) || (op == op_call);
                        bus.paddr  <= (op == op_ret) ? regs[rs1_idx] : alu_result;
                        bus.pwdata <= store_data;
                        state      <= st_mem;
                    end else begin
                        state <= st_wb;
                    end
                end
                st_wb: begin
                    pc         <= pc_next;
                    bus.psel   <= 1'b1;          // Next fetch, no idle cycle
                    bus.pwrite <= 1'b0;
                    bus.paddr  <= pc_next;
                    state      <= st_fetch;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/ex_unit.sv ====
// Execute stage: operand select, ALU, flag register, next-PC and store/destination select
`timescale 1ns/1ns
`default_nettype none

module ex_unit import cpu16_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  word_t      rs1_data,                 // Operand 1
    input  word_t      rs2_data,                 // Operand 2 or store data
    input  word_t      sign_ext,                 // Immediate or branch offset
    input  logic       alu_src,                  // 1 selects sign_ext
    input  alu_op_e    alu_op,
    input  logic [3:0] shamt,
    input  logic [7:0] imm8,
    input  logic       alu_done,                 // Load flags this edge
    input  logic       branch,
    input  logic       call,
    input  logic       ret,
    input  br_cond_e   br_cond,
    input  logic [11:0] call_target,
    input  word_t      pc,
    input  word_t      ret_addr,                 // Word popped from the stack
    input  logic [3:0] rd_in,
    output word_t      alu_result,
    output word_t      store_data,
    output word_t      pc_next,
    output logic [3:0] rd_out,
    output flags_t     flags                     // Stored flags
);

    word_t  op2;
    word_t  pc_inc;
    flags_t alu_flags;                           // Flags of the current ALU op
    logic   taken;

    assign op2    = alu_src ? sign_ext : rs2_data;
    assign pc_inc = pc + 16'd1;

    alu alu_i (
        .a      (rs1_data),
        .b      (op2),
        .shamt  (shamt),
        .imm8   (imm8),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (alu_done) begin
            flags <= alu_flags;                  // Only completed ALU ops touch flags
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // PC update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (br_cond)
            br_always: taken = 1'b1;
            br_eq:     taken = flags.z;
            br_ne:     taken = !flags.z;
            br_lt:     taken = flags.n;
            br_ge:     taken = !flags.n;
            br_cs:     taken = flags.c;
            default:   taken = 1'b0;             // Reserved codes fall through
        endcase
    end

    always_comb begin
        if (branch && taken) pc_next = pc_inc + sign_ext;  // Relative to next instr
        else if (call)       pc_next = {4'b0, call_target};
        else if (ret)        pc_next = ret_addr;
        else                 pc_next = pc_inc;
    end

    assign store_data = call ? pc_inc : rs2_data;  // Call pushes return PC
    assign rd_out     = call ? sp_reg : rd_in;     // Call writes back new SP

endmodule

`default_nettype wire
